/* hdl/dma_pkg.sv */
package dma_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 64;
  localparam int CNT_W  = 24;
  localparam int IP_W   = 3;

  // One entry of the command table
  typedef struct packed {
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dest_addr;
    logic [CNT_W-1:0]  count;
    logic [IP_W-1:0]   next;
    logic              src_addr_rst;
    logic              dest_addr_rst;
    logic              cont;
    logic              dest_quantum;
    logic              dest_inc;
    logic              dest_dec;
  } cmd_t;

  typedef struct packed {
    logic            enable;
    logic            src_inc;
    logic            src_dec;
    logic [IP_W-1:0] start_ip;
  } ctrl_t;

  typedef struct packed {
    logic busy;
    logic finished;
  } status_t;

  // Word passed from source port to sink port
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } word_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP_CMD,
    ACTIVE,
    END_CMD,
    FLUSH,
    FINISHED
  } chan_state_t;

endpackage

/* hdl/dma_source_port.sv */
`timescale 1ns/1ps

module dma_source_port (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_run,
  input  logic                       i_grant,
  input  logic                       i_flush,
  output logic                       o_avail,
  output logic                       o_idle,
  output dma_pkg::word_t             o_word,
  output logic                       o_src_activate,
  input  logic                       i_src_ready,
  input  logic [dma_pkg::CNT_W-1:0]  i_src_size,
  output logic                       o_src_strobe,
  input  logic [dma_pkg::DATA_W-1:0] i_src_data
);
  import dma_pkg::*;

  logic [CNT_W-1:0] blk_cnt;
  logic             granted;
  logic             take;

  assign o_avail = o_src_activate && (blk_cnt < i_src_size);
  assign o_idle  = !o_src_activate;

  // One word per grant, or on our own while draining
  assign take = o_avail && (i_grant || i_flush);

  // Drained words are read out but dropped
  assign o_word.valid = o_src_strobe && granted;
  assign o_word.data  = i_src_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_src_activate <= 1'b0;
      o_src_strobe   <= 1'b0;
      granted        <= 1'b0;
      blk_cnt        <= '0;
    end else begin
      o_src_strobe <= take;
      granted      <= i_grant;
      if (take) begin
        blk_cnt <= blk_cnt + 1'b1;
      end
      if (!o_src_activate) begin
        // No new block once flush has started
        if (i_run && !i_flush && i_src_ready) begin
          o_src_activate <= 1'b1;
          blk_cnt        <= '0;
        end
      end else if (blk_cnt >= i_src_size) begin
        o_src_activate <= 1'b0;
      end
    end
  end

  // No strobe beyond the end of the open block
  assert property (@(posedge clk) disable iff (rst)
    o_src_strobe |-> o_src_activate && (blk_cnt <= i_src_size));

endmodule

/* hdl/dma_channel_ctrl.sv */
`timescale 1ns/1ps

module dma_channel_ctrl #(
  parameter int NUM_CMDS = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  dma_pkg::ctrl_t             i_ctrl,
  input  dma_pkg::cmd_t              i_cmds [NUM_CMDS],
  input  logic                       i_avail,
  input  logic                       i_space,
  input  logic                       i_written,
  input  logic                       i_src_idle,
  input  logic                       i_snk_idle,
  output logic                       o_run,
  output logic                       o_grant,
  output logic                       o_flush,
  output logic                       o_close,
  output logic                       o_pad,
  output logic [dma_pkg::ADDR_W-1:0] o_src_address,
  output logic [dma_pkg::ADDR_W-1:0] o_snk_address,
  output dma_pkg::status_t           o_status
);
  import dma_pkg::*;

  chan_state_t      state;
  logic [IP_W-1:0]  ip;
  logic [CNT_W-1:0] remaining;
  logic [1:0]       pending;
  logic             drained;
  cmd_t             cmd;

  function automatic logic [ADDR_W-1:0] step_addr(input logic [ADDR_W-1:0] addr,
                                                  input logic inc,
                                                  input logic dec);
    if (inc) begin
      return addr + 1'b1;
    end
    if (dec) begin
      return addr - 1'b1;
    end
    return addr;
  endfunction

  assign cmd     = i_cmds[ip];
  // Granted words not yet written to the sink
  assign drained = (pending == 2'd0);

  assign o_run   = (state == ACTIVE) || (state == FLUSH);
  assign o_flush = (state == FLUSH);
  assign o_pad   = o_flush && cmd.dest_quantum;
  assign o_grant = (state == ACTIVE) && i_ctrl.enable && i_avail && i_space &&
                   (remaining != '0);

  // Partial block ends at command end and in flush once nothing is in flight
  assign o_close = !cmd.dest_quantum && ((state == END_CMD) || (o_flush && drained));

  assign o_status.busy     = (state != IDLE) && (state != FINISHED);
  assign o_status.finished = (state == FINISHED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      ip        <= '0;
      remaining <= '0;
      pending   <= 2'd0;
    end else begin
      pending <= pending + 2'(o_grant) - 2'(i_written);
      case (state)
        IDLE: begin
          if (i_ctrl.enable) begin
            ip    <= i_ctrl.start_ip;
            state <= SETUP_CMD;
          end
        end
        SETUP_CMD: begin
          remaining <= cmd.count;
          state     <= ACTIVE;
        end
        ACTIVE: begin
          if (o_grant) begin
            remaining <= remaining - 1'b1;
          end
          if (!i_ctrl.enable) begin
            state <= FLUSH;
          end else if ((remaining == '0) && drained) begin
            state <= END_CMD;
          end
        end
        END_CMD: begin
          if (cmd.cont) begin
            ip    <= cmd.next;
            state <= SETUP_CMD;
          end else begin
            state <= FLUSH;
          end
        end
        FLUSH: begin
          if (drained && i_src_idle && i_snk_idle) begin
            state <= FINISHED;
          end
        end
        FINISHED: begin
          if (!i_ctrl.enable) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Live address counters
  always_ff @(posedge clk) begin
    if (o_grant) begin
      o_src_address <= step_addr(o_src_address, i_ctrl.src_inc, i_ctrl.src_dec);
    end
    if (i_written) begin
      o_snk_address <= step_addr(o_snk_address, cmd.dest_inc, cmd.dest_dec);
    end
    case (state)
      IDLE: begin
        if (i_ctrl.enable) begin
          o_src_address <= i_cmds[i_ctrl.start_ip].src_addr;
          o_snk_address <= i_cmds[i_ctrl.start_ip].dest_addr;
        end
      end
      SETUP_CMD: begin
        if (cmd.src_addr_rst) begin
          o_src_address <= cmd.src_addr;
        end
        if (cmd.dest_addr_rst) begin
          o_snk_address <= cmd.dest_addr;
        end
      end
      default: begin
      end
    endcase
  end

  // A grant reaches the sink as a write two cycles later
  assert property (@(posedge clk) disable iff (rst)
    o_grant |-> ##2 i_written);

endmodule

/* hdl/dma_sink_port.sv */
`timescale 1ns/1ps

module dma_sink_port (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_run,
  input  dma_pkg::word_t             i_word,
  input  logic                       i_close,
  input  logic                       i_pad,
  output logic                       o_space,
  output logic                       o_written,
  output logic                       o_idle,
  input  logic [1:0]                 i_snk_ready,
  output logic [1:0]                 o_snk_activate,
  input  logic [dma_pkg::CNT_W-1:0]  i_snk_size,
  output logic                       o_snk_strobe,
  output logic [dma_pkg::DATA_W-1:0] o_snk_data
);
  import dma_pkg::*;

  logic [CNT_W-1:0] blk_cnt;
  logic             bank_open;
  logic             pad_now;
  logic             put;

  assign bank_open = |o_snk_activate;
  assign o_idle    = !bank_open;

  // Word in the source strobe cycle already holds a slot
  assign o_space = bank_open && ((blk_cnt + CNT_W'(i_word.valid)) < i_snk_size);

  // Zeros only fill slots no data word is heading for
  assign pad_now = i_pad && bank_open && !i_word.valid && (blk_cnt < i_snk_size);
  assign put     = i_word.valid || pad_now;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_snk_activate <= 2'b00;
      o_snk_strobe   <= 1'b0;
      o_written      <= 1'b0;
      blk_cnt        <= '0;
    end else begin
      o_snk_strobe <= put;
      o_written    <= i_word.valid;
      if (put) begin
        blk_cnt <= blk_cnt + 1'b1;
      end
      if (!bank_open) begin
        if (i_run && !i_pad && !i_close && (|i_snk_ready)) begin
          // Bank 0 wins when both are ready
          o_snk_activate <= i_snk_ready[0] ? 2'b01 : 2'b10;
          blk_cnt        <= '0;
        end
      end else if ((blk_cnt >= i_snk_size) || i_close) begin
        o_snk_activate <= 2'b00;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (put) begin
      o_snk_data <= i_word.valid ? i_word.data : '0;
    end
  end

  // Writes land inside the bank that was open when they were issued
  assert property (@(posedge clk) disable iff (rst)
    o_snk_strobe |-> bank_open && $past(bank_open));

endmodule

/* hdl/dma_top.sv */
`timescale 1ns/1ps

module dma_top #(
  parameter int NUM_CMDS = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  dma_pkg::ctrl_t             i_ctrl,
  input  dma_pkg::cmd_t              i_cmds [NUM_CMDS],
  output dma_pkg::status_t           o_status,
  input  logic                       i_src_ready,
  output logic                       o_src_activate,
  input  logic [dma_pkg::CNT_W-1:0]  i_src_size,
  output logic                       o_src_strobe,
  input  logic [dma_pkg::DATA_W-1:0] i_src_data,
  input  logic [1:0]                 i_snk_ready,
  output logic [1:0]                 o_snk_activate,
  input  logic [dma_pkg::CNT_W-1:0]  i_snk_size,
  output logic                       o_snk_strobe,
  output logic [dma_pkg::DATA_W-1:0] o_snk_data,
  output logic [dma_pkg::ADDR_W-1:0] o_src_address,
  output logic [dma_pkg::ADDR_W-1:0] o_snk_address
);
  import dma_pkg::*;

  word_t word;
  logic  run;
  logic  grant;
  logic  flush;
  logic  close;
  logic  pad;
  logic  avail;
  logic  space;
  logic  written;
  logic  src_idle;
  logic  snk_idle;

  dma_source_port dma_source_port_inst (
    .clk,
    .rst,
    .i_run          (run),
    .i_grant        (grant),
    .i_flush        (flush),
    .o_avail        (avail),
    .o_idle         (src_idle),
    .o_word         (word),
    .o_src_activate,
    .i_src_ready,
    .i_src_size,
    .o_src_strobe,
    .i_src_data
  );

  dma_channel_ctrl #(
    .NUM_CMDS (NUM_CMDS)
  ) dma_channel_ctrl_inst (
    .clk,
    .rst,
    .i_ctrl,
    .i_cmds,
    .i_avail    (avail),
    .i_space    (space),
    .i_written  (written),
    .i_src_idle (src_idle),
    .i_snk_idle (snk_idle),
    .o_run      (run),
    .o_grant    (grant),
    .o_flush    (flush),
    .o_close    (close),
    .o_pad      (pad),
    .o_src_address,
    .o_snk_address,
    .o_status
  );

  dma_sink_port dma_sink_port_inst (
    .clk,
    .rst,
    .i_run     (run),
    .i_word    (word),
    .i_close   (close),
    .i_pad     (pad),
    .o_space   (space),
    .o_written (written),
    .o_idle    (snk_idle),
    .i_snk_ready,
    .o_snk_activate,
    .i_snk_size,
    .o_snk_strobe,
    .o_snk_data
  );

endmodule

/* tests/tb_dma_model.svh */
`ifndef TB_DMA_MODEL_SVH
`define TB_DMA_MODEL_SVH

logic [31:0]       lcg_state = 32'h1778_3895;
logic [DATA_W-1:0] src_head;
bit                head_used;
logic [DATA_W-1:0] src_log [$];
logic [DATA_W-1:0] snk_log [$];
int                blk_words;
logic [1:0]        prev_act;
bit                src_act_d;
int                src_blk_words;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Source FIFO hands out a rising sequence with random steps
task automatic source_cycle();
  logic [31:0] r;
  r = lcg_next();
  // Ready still holds the level the last rising edge sampled
  if (o_src_activate && !src_act_d) begin
    src_blk_words = 0;
    assert (i_src_ready) else begin
      other_errs++;
      $display("Source block opened while the source FIFO was not ready");
    end
  end
  src_act_d = o_src_activate;
  if (head_used) begin
    src_head = src_head + 1 + r[31:28];
  end
  // Word on the bus now is taken at the next rising edge
  head_used = o_src_strobe;
  if (o_src_strobe) begin
    src_log.push_back(src_head);
    src_blk_words++;
    assert (o_src_activate) else begin
      other_errs++;
      $display("Source strobe while no block is open");
    end
    assert (src_blk_words <= int'(i_src_size)) else begin
      other_errs++;
      $display("Source block read past its size");
    end
  end
  i_src_data  = src_head;
  i_src_ready = (r[27:26] != 2'b00);
endtask

task automatic sink_sample(input logic [CNT_W-1:0] size);
  assert (o_snk_activate != 2'b11) else begin
    other_errs++;
    $display("Both sink banks are active at the same time");
  end
  if ((o_snk_activate != 2'b00) && (prev_act == 2'b00)) begin
    blk_words = 0;
    // Bank 0 wins whenever it was ready
    assert (((o_snk_activate & i_snk_ready) != 2'b00) &&
            !(i_snk_ready[0] && o_snk_activate[1])) else begin
      other_errs++;
      $display("Sink opened a bank that was not ready or passed over bank 0");
    end
  end
  prev_act = o_snk_activate;
  if (o_snk_strobe) begin
    snk_log.push_back(o_snk_data);
    blk_words++;
    assert (o_snk_activate != 2'b00) else begin
      other_errs++;
      $display("Sink strobe while no bank is open");
    end
    assert (blk_words <= int'(size)) else begin
      other_errs++;
      $display("Sink block holds more words than its size");
    end
  end
endtask

// Walk the chain from start_ip, track total words and both addresses
task automatic predict(input ctrl_t ctrl, output int total, output logic [ADDR_W-1:0] src,
                       output logic [ADDR_W-1:0] dst, output bit last_dq);
  int ip;
  bit done;
  ip    = ctrl.start_ip;
  total = 0;
  done  = 1'b0;
  src   = i_cmds[ip].src_addr;
  dst   = i_cmds[ip].dest_addr;
  while (!done) begin
    if (i_cmds[ip].src_addr_rst) begin
      src = i_cmds[ip].src_addr;
    end
    if (i_cmds[ip].dest_addr_rst) begin
      dst = i_cmds[ip].dest_addr;
    end
    total += int'(i_cmds[ip].count);
    if (ctrl.src_inc) begin
      src = src + i_cmds[ip].count;
    end else if (ctrl.src_dec) begin
      src = src - i_cmds[ip].count;
    end
    if (i_cmds[ip].dest_inc) begin
      dst = dst + i_cmds[ip].count;
    end else if (i_cmds[ip].dest_dec) begin
      dst = dst - i_cmds[ip].count;
    end
    last_dq = i_cmds[ip].dest_quantum;
    done    = !i_cmds[ip].cont;
    ip      = i_cmds[ip].next;
  end
endtask

`endif

/* tests/tb_dma_top.sv */
`timescale 1ns/1ps

module tb_dma_top;
  import dma_pkg::*;

  localparam int NUM_CMDS     = 8;
  localparam int NUM_PROGRAMS = 12;
  localparam int TIMEOUT      = 5000;

  logic              clk;
  logic              rst;
  ctrl_t             i_ctrl;
  cmd_t              i_cmds [NUM_CMDS];
  status_t           o_status;
  logic              i_src_ready;
  logic              o_src_activate;
  logic [CNT_W-1:0]  i_src_size;
  logic              o_src_strobe;
  logic [DATA_W-1:0] i_src_data;
  logic [1:0]        i_snk_ready;
  logic [1:0]        o_snk_activate;
  logic [CNT_W-1:0]  i_snk_size;
  logic              o_snk_strobe;
  logic [DATA_W-1:0] o_snk_data;
  logic [ADDR_W-1:0] o_src_address;
  logic [ADDR_W-1:0] o_snk_address;
  int                mismatch_errs;
  int                other_errs;
  bit                timed_out;

  `include "tb_dma_model.svh"

  dma_top #(
    .NUM_CMDS (NUM_CMDS)
  ) dma_top_inst (
    .clk, .rst, .i_ctrl, .i_cmds, .o_status,
    .i_src_ready, .o_src_activate, .i_src_size, .o_src_strobe, .i_src_data,
    .i_snk_ready, .o_snk_activate, .i_snk_size, .o_snk_strobe, .o_snk_data,
    .o_src_address, .o_snk_address
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      mismatch_errs++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Sample at the falling edge, then drive the next inputs
  task automatic step_cycle();
    logic [31:0] r;
    @(negedge clk);
    sink_sample(i_snk_size);
    source_cycle();
    r = lcg_next();
    i_snk_ready = r[31:30];
  endtask

  task automatic make_program();
    logic [31:0] r;
    for (int i = 0; i < NUM_CMDS; i++) begin
      r = lcg_next();
      i_cmds[i].src_addr[63:32]  = lcg_next();
      i_cmds[i].src_addr[31:0]   = lcg_next();
      i_cmds[i].dest_addr[63:32] = lcg_next();
      i_cmds[i].dest_addr[31:0]  = lcg_next();
      i_cmds[i].count         = CNT_W'(1 + r[3:0] % 12);
      // Next always points forward so every chain ends
      i_cmds[i].next          = IP_W'(i + 1 + r[4]);
      i_cmds[i].cont          = (r[6:5] != 2'b00) && (i + 1 + r[4] < NUM_CMDS);
      i_cmds[i].src_addr_rst  = r[7];
      i_cmds[i].dest_addr_rst = r[8];
      i_cmds[i].dest_quantum  = r[9];
      i_cmds[i].dest_inc      = (r[11:10] == 2'd1);
      i_cmds[i].dest_dec      = (r[11:10] == 2'd2);
    end
    r = lcg_next();
    i_ctrl.src_inc  = (r[1:0] == 2'd1);
    i_ctrl.src_dec  = (r[1:0] == 2'd2);
    i_ctrl.start_ip = IP_W'(r[3:2]);
    i_src_size      = CNT_W'(1 + r[6:4]);
    i_snk_size      = CNT_W'(1 + r[9:7]);
  endtask

  task automatic run_program();
    int                cycles;
    int                total;
    bit                last_dq;
    logic [ADDR_W-1:0] exp_src;
    logic [ADDR_W-1:0] exp_dst;
    logic [DATA_W-1:0] exp_word;
    make_program();
    predict(i_ctrl, total, exp_src, exp_dst, last_dq);
    src_log.delete();
    snk_log.delete();
    i_ctrl.enable = 1'b1;
    cycles = 0;
    while (!o_status.finished && (cycles < TIMEOUT)) begin
      step_cycle();
      cycles++;
      assert (o_status.busy || o_status.finished) else begin
        other_errs++;
        $display("busy is low while the program runs");
      end
    end
    assert (o_status.finished) else begin
      other_errs++;
      timed_out = 1'b1;
      $display("Timed out waiting for finished");
    end
    if (timed_out) begin
      return;
    end
    check_value("o_src_address", o_src_address, exp_src);
    check_value("o_snk_address", o_snk_address, exp_dst);
    // Padding after the data words must be zero
    for (int i = 0; i < snk_log.size(); i++) begin
      exp_word = ((i < total) && (i < src_log.size())) ? src_log[i] : '0;
      check_value("o_snk_data", snk_log[i], exp_word);
    end
    if (last_dq) begin
      assert (snk_log.size() >= total) else begin
        other_errs++;
        $display("Sink received fewer words than the commands moved");
      end
      check_value("o_snk_strobe words in last block", blk_words, i_snk_size);
    end else begin
      check_value("o_snk_strobe count", snk_log.size(), total);
    end
    i_ctrl.enable = 1'b0;
    cycles = 0;
    while ((o_status.busy || o_status.finished) && (cycles < TIMEOUT)) begin
      step_cycle();
      cycles++;
    end
    assert (!o_status.busy && !o_status.finished) else begin
      other_errs++;
      timed_out = 1'b1;
      $display("Timed out waiting for the engine to return to idle");
    end
  endtask

  initial begin
    rst           = 1'b1;
    i_ctrl        = '0;
    i_src_ready   = 1'b0;
    i_src_size    = CNT_W'(1);
    i_src_data    = '0;
    i_snk_ready   = 2'b00;
    i_snk_size    = CNT_W'(1);
    mismatch_errs = 0;
    other_errs    = 0;
    timed_out     = 1'b0;
    src_head      = 32'h0000_1000;
    head_used     = 1'b0;
    prev_act      = 2'b00;
    blk_words     = 0;
    src_act_d     = 1'b0;
    src_blk_words = 0;
    foreach (i_cmds[i]) begin
      i_cmds[i] = '0;
    end
    repeat (4) step_cycle();
    rst = 1'b0;
    for (int p = 0; (p < NUM_PROGRAMS) && !timed_out; p++) begin
      run_program();
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if ((mismatch_errs + other_errs) == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* dma_lite.f */
+incdir+tests
hdl/dma_pkg.sv
hdl/dma_source_port.sv
hdl/dma_channel_ctrl.sv
hdl/dma_sink_port.sv
hdl/dma_top.sv
tests/tb_dma_top.sv

/* Bender.yml */
package:
  name: dma_lite

sources:
  - files:
      - hdl/dma_pkg.sv
      - hdl/dma_source_port.sv
      - hdl/dma_channel_ctrl.sv
      - hdl/dma_sink_port.sv
      - hdl/dma_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dma_top.sv
